// File: sim.f
source/core_sizes_pkg.sv
source/rename_types_pkg.sv
source/dispatch_if.sv
source/retire_if.sv
source/map_table.sv
source/free_list.sv
source/reorder_buffer.sv
source/completion_select.sv
source/rename_core.sv
tb/rename_core_checker.sv
tb/rename_core_tb.sv

// File: Makefile
# Verilator build and run for the rename core testbench

VERILATOR ?= verilator
TOP       ?= rename_core_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(wildcard source/*.sv tb/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "sim passed" $(LOG) || { echo "FAIL: run did not finish, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/rename_core_tb.sv
`timescale 1ns/100ps

module rename_core_tb
  import core_sizes_pkg::*;
  import rename_types_pkg::*;
();

  localparam logic [31:0] lfsr_seed = 32'h362a_ffbe;
  localparam int random_cycles = 400;
  localparam int wait_limit    = 200;

  // one in-flight instruction as the model sees it
  typedef struct {
    arch_reg_t dest;
    phys_tag_t t_new;
    phys_tag_t t_old;
  } inflight_t;

  logic                      clock;
  logic                      reset;
  logic                      dispatch_valid;
  arch_reg_t                 dispatch_dest;
  arch_reg_t                 dispatch_src_a;
  arch_reg_t                 dispatch_src_b;
  logic                      dispatch_ready;
  phys_tag_t                 tag_a;
  phys_tag_t                 tag_b;
  phys_tag_t                 tag_new;
  phys_tag_t                 tag_old;
  logic      [num_units-1:0] complete_req;
  phys_tag_t [num_units-1:0] complete_tag;
  logic      [num_units-1:0] complete_grant;
  logic                      cdb_valid;
  phys_tag_t                 cdb_tag;
  logic                      retire_valid;
  arch_reg_t                 retire_arch_reg;
  phys_tag_t                 retire_tag_new;
  phys_tag_t                 retire_tag_old;

  // reference model of map, free list order and rob
  phys_tag_t                 map_m [num_arch_regs];
  bit                        done_m [num_phys_regs];
  phys_tag_t                 free_q [$];
  inflight_t                 rob_q [$];
  // dispatched tags no unit has picked up yet
  phys_tag_t                 pool_q [$];
  logic      [num_units-1:0] req_m;
  phys_tag_t [num_units-1:0] tag_m;
  logic                      exp_cdb_valid;
  phys_tag_t                 exp_cdb_tag;

  logic [31:0] lfsr_q;
  int          checks;
  int          errors;
  bit          stalled;

  rename_core #(
    .num_arch_regs (num_arch_regs),
    .num_phys_regs (num_phys_regs),
    .rob_depth     (rob_depth),
    .num_units     (num_units)
  ) dut (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic int unsigned take_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_q[0]);
      lfsr_q = next_lfsr(lfsr_q);
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // every idle unit grabs the youngest waiting tag at once
  task automatic load_all_units();
    for (int u = 0; u < num_units; u++) begin
      if (!req_m[u] && pool_q.size() > 0) begin
        tag_m[u] = pool_q.pop_back();
        req_m[u] = 1'b1;
      end
    end
  endtask

  // one clock cycle with dsp_mode 0 idle, 1 random or 2 every cycle
  task automatic run_cycle(input int dsp_mode, input bit cmp_en);
    arch_reg_t            dest;
    arch_reg_t            sa;
    arch_reg_t            sb;
    logic [num_units-1:0] exp_grant;
    logic                 ready_m;
    logic                 head_done;
    logic                 do_dsp;
    int                   idx;
    int                   win;
    inflight_t            ent;

    @(negedge clock);
    // random pick from the pool makes completions come out of order
    if (cmp_en) begin
      for (int u = 0; u < num_units; u++) begin
        if (!req_m[u] && pool_q.size() > 0 && take_bits(2) != 0) begin
          idx = int'(take_bits(4)) % pool_q.size();
          tag_m[u] = pool_q[idx];
          pool_q.delete(idx);
          req_m[u] = 1'b1;
        end
      end
    end
    dest   = arch_reg_t'(take_bits(arch_width));
    sa     = arch_reg_t'(take_bits(arch_width));
    sb     = arch_reg_t'(take_bits(arch_width));
    do_dsp = (dsp_mode == 2) || (dsp_mode == 1 && take_bits(2) != 0);
    dispatch_valid = do_dsp;
    dispatch_dest  = dest;
    dispatch_src_a = sa;
    dispatch_src_b = sb;
    complete_req   = req_m;
    complete_tag   = tag_m;
    #1;

    // rename side is all combinational
    ready_m = free_q.size() > 0 && rob_q.size() < rob_depth;
    check_value("dispatch_ready", 32'(ready_m), 32'(dispatch_ready));
    check_value("tag_a", 32'(map_m[sa]), 32'(tag_a));
    check_value("tag_b", 32'(map_m[sb]), 32'(tag_b));
    // head of the free list stays visible while the rob is full
    if (free_q.size() > 0) begin
      check_value("tag_new", 32'(free_q[0]), 32'(tag_new));
    end
    check_value("tag_old", 32'(map_m[dest]), 32'(tag_old));

    // lowest requesting unit wins
    win = -1;
    for (int u = 0; u < num_units && win < 0; u++) begin
      if (req_m[u]) begin
        win = u;
      end
    end
    exp_grant = '0;
    if (win >= 0) begin
      exp_grant[win] = 1'b1;
    end
    check_value("complete_grant", 32'(exp_grant), 32'(complete_grant));
    check_value("cdb_valid", 32'(exp_cdb_valid), 32'(cdb_valid));
    if (exp_cdb_valid) begin
      check_value("cdb_tag", 32'(exp_cdb_tag), 32'(cdb_tag));
    end

    // in-order retire
    head_done = 1'b0;
    if (rob_q.size() > 0) begin
      head_done = done_m[rob_q[0].t_new];
    end
    check_value("retire_valid", 32'(head_done), 32'(retire_valid));
    if (head_done) begin
      check_value("retire_arch_reg", 32'(rob_q[0].dest), 32'(retire_arch_reg));
      check_value("retire_tag_new", 32'(rob_q[0].t_new), 32'(retire_tag_new));
      check_value("retire_tag_old", 32'(rob_q[0].t_old), 32'(retire_tag_old));
    end

    // model follows the coming rising edge
    if (do_dsp && ready_m) begin
      ent.dest  = dest;
      ent.t_old = map_m[dest];
      ent.t_new = free_q.pop_front();
      map_m[dest] = ent.t_new;
      done_m[ent.t_new] = 1'b0;
      rob_q.push_back(ent);
      pool_q.push_back(ent.t_new);
    end
    if (head_done) begin
      ent = rob_q.pop_front();
      free_q.push_back(ent.t_old);
    end
    if (exp_cdb_valid) begin
      done_m[exp_cdb_tag] = 1'b1;
    end
    exp_cdb_valid = win >= 0;
    if (win >= 0) begin
      exp_cdb_tag = tag_m[win];
      req_m[win]  = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int n;

    lfsr_q  = lfsr_seed;
    checks  = 0;
    errors  = 0;
    stalled = 1'b0;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_dest  = '0;
    dispatch_src_a = '0;
    dispatch_src_b = '0;
    complete_req   = '0;
    complete_tag   = '0;
    req_m          = '0;
    tag_m          = '0;
    exp_cdb_valid  = 1'b0;
    exp_cdb_tag    = '0;
    // identity map and the remaining tags free in ascending order
    for (int i = 0; i < num_arch_regs; i++) begin
      map_m[i] = phys_tag_t'(i);
    end
    for (int i = num_arch_regs; i < num_phys_regs; i++) begin
      free_q.push_back(phys_tag_t'(i));
    end

    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // state right after reset
    for (int r = 0; r < num_arch_regs; r++) begin
      @(negedge clock);
      dispatch_src_a = arch_reg_t'(r);
      dispatch_src_b = arch_reg_t'(num_arch_regs - 1 - r);
      #1;
      check_value("reset tag_a", 32'(r), 32'(tag_a));
      check_value("reset tag_b", 32'(num_arch_regs - 1 - r), 32'(tag_b));
      check_value("reset dispatch_ready", 32'd1, 32'(dispatch_ready));
      check_value("reset cdb_valid", 32'd0, 32'(cdb_valid));
      check_value("reset retire_valid", 32'd0, 32'(retire_valid));
      check_value("reset complete_grant", 32'd0, 32'(complete_grant));
    end

    // fill the rob with nothing completing
    n = 0;
    while (rob_q.size() < rob_depth && !stalled) begin
      run_cycle(2, 1'b0);
      n++;
      if (n >= wait_limit) begin
        $display("timed out waiting for the rob to fill");
        stalled = 1'b1;
      end
    end
    // pulses while stalled must not move any tag
    repeat (4) run_cycle(2, 1'b0);
    check_value("ready with rob full", 32'd0, 32'(dispatch_ready));

    // all units request together
    load_all_units();
    repeat (num_units + 2) run_cycle(0, 1'b0);

    // random mix of dispatch and out-of-order completion
    for (int c = 0; c < random_cycles && !stalled; c++) begin
      run_cycle(1, 1'b1);
    end

    // drain
    n = 0;
    while ((rob_q.size() > 0 || req_m != '0 || exp_cdb_valid) && !stalled) begin
      run_cycle(0, 1'b1);
      n++;
      if (n >= wait_limit) begin
        $display("timed out waiting for the rob to drain");
        stalled = 1'b1;
      end
    end

    $display("checks %0d, errors %0d, checker failures %0d",
             checks, errors, dut.u_checker.failures);
    if (!stalled && errors == 0 && dut.u_checker.failures == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: tb/rename_core_checker.sv
`timescale 1ns/100ps

module rename_core_checker
  import core_sizes_pkg::*;
  import rename_types_pkg::*;
#(
  parameter int num_units    = core_sizes_pkg::num_units,
  parameter int fl_ptr_width = $clog2(num_phys_regs - num_arch_regs)
) (
  input logic                      clock,
  input logic                      reset,
  input logic      [num_units-1:0] complete_req,
  input phys_tag_t [num_units-1:0] complete_tag,
  input logic      [num_units-1:0] complete_grant,
  input logic                      cdb_valid,
  input phys_tag_t                 cdb_tag,
  input logic                      retire_valid,
  input logic                      dispatch_ready,
  input logic  [rob_ptr_width-1:0] rob_tail,
  input logic   [fl_ptr_width-1:0] fl_head
);

  // failed assertions counted for the testbench summary
  int failures = 0;

  // tag of whichever unit holds the grant
  phys_tag_t grant_tag;

  always_comb begin
    grant_tag = '0;
    for (int i = 0; i < num_units; i++) begin
      if (complete_grant[i]) begin
        grant_tag = complete_tag[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // completion select
  //////////////////////////////////////////////////////////////////////

  grant_one_hot: assert property (@(posedge clock) disable iff (reset)
    $onehot0(complete_grant))
    else begin
      failures++;
      $error("completion grant has more than one bit set");
    end

  // someone requesting means the lowest requester holds the grant
  grant_lowest: assert property (@(posedge clock) disable iff (reset)
    |complete_req |-> (complete_grant & complete_req) == complete_grant &&
                      |complete_grant &&
                      ((complete_grant - 1'b1) & complete_req) == '0)
    else begin
      failures++;
      $error("a lower indexed completion request was left without the grant");
    end

  cdb_after_grant: assert property (@(posedge clock) disable iff (reset)
    |complete_grant |=> cdb_valid && cdb_tag == $past(grant_tag))
    else begin
      failures++;
      $error("cdb did not carry the granted tag one cycle after the grant");
    end

  cdb_idle: assert property (@(posedge clock) disable iff (reset)
    !(|complete_grant) |=> !cdb_valid)
    else begin
      failures++;
      $error("cdb went valid without a grant in the cycle before");
    end

  //////////////////////////////////////////////////////////////////////
  // retire and dispatch
  //////////////////////////////////////////////////////////////////////

  no_retire_in_reset: assert property (@(posedge clock)
    reset |-> !$rose(retire_valid))
    else begin
      failures++;
      $error("retire_valid rose while reset was high");
    end

  // a stalled cycle allocates no rob slot and pops no free tag
  no_dispatch_when_stalled: assert property (@(posedge clock) disable iff (reset)
    !dispatch_ready |=> $stable(rob_tail) && $stable(fl_head))
    else begin
      failures++;
      $error("a dispatch was accepted while dispatch_ready was low");
    end

endmodule

bind rename_core rename_core_checker #(
  .num_units (num_units)
) u_checker (
  .clock          (clock),
  .reset          (reset),
  .complete_req   (complete_req),
  .complete_tag   (complete_tag),
  .complete_grant (complete_grant),
  .cdb_valid      (cdb_valid),
  .cdb_tag        (cdb_tag),
  .retire_valid   (retire_valid),
  .dispatch_ready (dispatch_ready),
  .rob_tail       (u_reorder_buffer.tail_q),
  .fl_head        (u_free_list.head_q)
);

// File: source/rename_core.sv
`timescale 1ns/100ps

module rename_core
  import core_sizes_pkg::*;
  import rename_types_pkg::*;
#(
  parameter int num_arch_regs = core_sizes_pkg::num_arch_regs,
  parameter int num_phys_regs = core_sizes_pkg::num_phys_regs,
  parameter int rob_depth     = core_sizes_pkg::rob_depth,
  parameter int num_units     = core_sizes_pkg::num_units
) (
  input  logic                      clock,
  input  logic                      reset,
  // dispatch, one instruction per cycle
  input  logic                      dispatch_valid,
  input  arch_reg_t                 dispatch_dest,
  input  arch_reg_t                 dispatch_src_a,
  input  arch_reg_t                 dispatch_src_b,
  output logic                      dispatch_ready,
  output phys_tag_t                 tag_a,
  output phys_tag_t                 tag_b,
  output phys_tag_t                 tag_new,
  output phys_tag_t                 tag_old,
  // unit completions and the cdb
  input  logic      [num_units-1:0] complete_req,
  input  phys_tag_t [num_units-1:0] complete_tag,
  output logic      [num_units-1:0] complete_grant,
  output logic                      cdb_valid,
  output phys_tag_t                 cdb_tag,
  // retirement
  output logic                      retire_valid,
  output arch_reg_t                 retire_arch_reg,
  output phys_tag_t                 retire_tag_new,
  output phys_tag_t                 retire_tag_old
);

  logic fl_empty;
  logic rob_full;

  dispatch_if dsp ();
  retire_if   ret ();

  ////////////////////////////////////////////////////////////////////
  // dispatch handshake
  ////////////////////////////////////////////////////////////////////

  // stall on no free tag or no rob slot
  assign dispatch_ready = ~(fl_empty | rob_full);
  assign dsp.valid      = dispatch_valid & dispatch_ready;
  assign dsp.arch_dest  = dispatch_dest;

  assign tag_new = dsp.t_new;
  assign tag_old = dsp.t_old;

  assign retire_valid    = ret.valid;
  assign retire_arch_reg = ret.arch_dest;
  assign retire_tag_new  = ret.t_new;
  assign retire_tag_old  = ret.t_old;

  ////////////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////////////

  map_table #(
    .num_arch_regs (num_arch_regs),
    .tag_width     (tag_width)
  ) u_map_table (
    .clock (clock),
    .reset (reset),
    .src_a (dispatch_src_a),
    .src_b (dispatch_src_b),
    .tag_a (tag_a),
    .tag_b (tag_b),
    .dsp   (dsp.source)
  );

  free_list #(
    .num_arch_regs (num_arch_regs),
    .num_phys_regs (num_phys_regs)
  ) u_free_list (
    .clock (clock),
    .reset (reset),
    .dsp   (dsp.source),
    .ret   (ret.sink),
    .empty (fl_empty)
  );

  reorder_buffer #(
    .rob_depth (rob_depth)
  ) u_reorder_buffer (
    .clock     (clock),
    .reset     (reset),
    .dsp       (dsp.sink),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .ret       (ret.source),
    .full      (rob_full)
  );

  // priority pick onto the cdb
  completion_select #(
    .num_units (num_units)
  ) u_completion_select (
    .clock          (clock),
    .reset          (reset),
    .complete_req   (complete_req),
    .complete_tag   (complete_tag),
    .complete_grant (complete_grant),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag)
  );

endmodule

// File: source/completion_select.sv
`timescale 1ns/100ps

module completion_select
  import core_sizes_pkg::*;
  import rename_types_pkg::*;
#(
  parameter int num_units = core_sizes_pkg::num_units
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic      [num_units-1:0]   complete_req,
  input  phys_tag_t [num_units-1:0]   complete_tag,
  output logic      [num_units-1:0]   complete_grant,
  output logic                        cdb_valid,
  output phys_tag_t                   cdb_tag
);

  phys_tag_t sel_tag;

  // fixed priority, unit 0 wins
  // scan from the top so the lowest requester overwrites last
  always_comb begin
    complete_grant = '0;
    sel_tag        = complete_tag[0];
    for (int i = num_units - 1; i >= 0; i--) begin
      if (complete_req[i]) begin
        complete_grant    = '0;
        complete_grant[i] = 1'b1;
        sel_tag           = complete_tag[i];
      end
    end
  end

  // cdb broadcast one cycle after the grant
  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= |complete_req;
    end
  end

  always_ff @(posedge clock) begin
    cdb_tag <= sel_tag;
  end

endmodule

// File: source/reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer
  import core_sizes_pkg::*;
  import rename_types_pkg::*;
#(
  parameter int rob_depth = core_sizes_pkg::rob_depth
) (
  input  logic        clock,
  input  logic        reset,
  dispatch_if.sink    dsp,
  input  logic        cdb_valid,
  input  phys_tag_t   cdb_tag,
  retire_if.source    ret,
  output logic        full
);

  rob_entry_t               entries_q [rob_depth];
  logic [rob_ptr_width-1:0] head_q;
  logic [rob_ptr_width-1:0] tail_q;
  logic [rob_ptr_width:0]   count_q;
  rob_entry_t               head_entry;

  assign head_entry = entries_q[head_q];
  assign full       = count_q == (rob_ptr_width + 1)'(rob_depth);

  ////////////////////////////////////////////////////////////////////
  // retire port
  ////////////////////////////////////////////////////////////////////

  // an empty rob has a free head, so no false retire
  assign ret.valid     = head_entry.state == entry_done;
  assign ret.arch_dest = head_entry.arch_dest;
  assign ret.t_new     = head_entry.t_new;
  assign ret.t_old     = head_entry.t_old;

  ////////////////////////////////////////////////////////////////////
  // mark, retire, allocate
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rob_depth; i++) begin
        entries_q[i].state <= entry_free;
      end
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      // cam the broadcast tag against every waiting slot
      if (cdb_valid) begin
        for (int i = 0; i < rob_depth; i++) begin
          if (entries_q[i].state == entry_waiting && entries_q[i].t_new == cdb_tag) begin
            entries_q[i].state <= entry_done;
          end
        end
      end
      // in-order retire from the head
      if (ret.valid) begin
        entries_q[head_q].state <= entry_free;
        head_q <= (head_q == rob_ptr_width'(rob_depth - 1)) ? '0 : head_q + 1'b1;
      end
      // tail never equals a retiring head, full blocks dispatch
      if (dsp.valid) begin
        entries_q[tail_q] <= '{state:     entry_waiting,
                               arch_dest: dsp.arch_dest,
                               t_new:     dsp.t_new,
                               t_old:     dsp.t_old};
        tail_q <= (tail_q == rob_ptr_width'(rob_depth - 1)) ? '0 : tail_q + 1'b1;
      end
      case ({dsp.valid, ret.valid})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: source/free_list.sv
`timescale 1ns/100ps

module free_list
  import core_sizes_pkg::*;
  import rename_types_pkg::*;
#(
  parameter int num_arch_regs = core_sizes_pkg::num_arch_regs,
  parameter int num_phys_regs = core_sizes_pkg::num_phys_regs
) (
  input  logic       clock,
  input  logic       reset,
  dispatch_if.source dsp,
  retire_if.sink     ret,
  output logic       empty
);

  // at most this many tags are ever free at once
  localparam int fl_depth     = num_phys_regs - num_arch_regs;
  localparam int fl_ptr_width = $clog2(fl_depth);

  phys_tag_t               fifo_q [fl_depth];
  logic [fl_ptr_width-1:0] head_q;
  logic [fl_ptr_width-1:0] tail_q;
  logic [fl_ptr_width:0]   count_q;

  // next tag handed to dispatch
  assign dsp.t_new = fifo_q[head_q];
  assign empty     = count_q == '0;

  ////////////////////////////////////////////////////////////////////
  // pop on accepted dispatch, push on retire, both allowed together
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // preload the tags not claimed by the identity map
      for (int i = 0; i < fl_depth; i++) begin
        fifo_q[i] <= tag_width'(num_arch_regs + i);
      end
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= (fl_ptr_width + 1)'(fl_depth);
    end else begin
      if (dsp.valid) begin
        head_q <= (head_q == fl_ptr_width'(fl_depth - 1)) ? '0 : head_q + 1'b1;
      end
      if (ret.valid) begin
        fifo_q[tail_q] <= ret.t_old;
        tail_q         <= (tail_q == fl_ptr_width'(fl_depth - 1)) ? '0 : tail_q + 1'b1;
      end
      // occupancy
      case ({ret.valid, dsp.valid})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: source/map_table.sv
`timescale 1ns/100ps

module map_table
  import core_sizes_pkg::*;
  import rename_types_pkg::*;
#(
  parameter int num_arch_regs = core_sizes_pkg::num_arch_regs,
  parameter int tag_width     = core_sizes_pkg::tag_width
) (
  input  logic       clock,
  input  logic       reset,
  input  arch_reg_t  src_a,
  input  arch_reg_t  src_b,
  output phys_tag_t  tag_a,
  output phys_tag_t  tag_b,
  dispatch_if.source dsp
);

  // current speculative mapping, one tag per arch register
  logic [tag_width-1:0] map_q [num_arch_regs];

  // source lookups
  // these see the map before this edge's update
  assign tag_a = map_q[src_a];
  assign tag_b = map_q[src_b];

  // previous owner of the destination, freed when this one retires
  assign dsp.t_old = map_q[dsp.arch_dest];

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map out of reset
      for (int i = 0; i < num_arch_regs; i++) begin
        map_q[i] <= tag_width'(i);
      end
    end else if (dsp.valid) begin
      // destination now lives in the freshly popped tag
      map_q[dsp.arch_dest] <= dsp.t_new;
    end
  end

endmodule

// File: source/retire_if.sv
`timescale 1ns/100ps

// head of the rob leaving the machine
interface retire_if
  import rename_types_pkg::*;
();
  logic      valid;
  arch_reg_t arch_dest;
  phys_tag_t t_new;
  phys_tag_t t_old;

  // rob drives the whole retiring entry
  modport source (output valid, output arch_dest, output t_new, output t_old);

  // free list only needs the tag being released
  modport sink (input valid, input t_old);

endinterface

// File: source/dispatch_if.sv
`timescale 1ns/100ps

// one renamed instruction on its way into the rob
interface dispatch_if
  import rename_types_pkg::*;
();
  logic      valid;
  arch_reg_t arch_dest;
  phys_tag_t t_new;
  phys_tag_t t_old;

  // rename side, map table gives t_old, free list gives t_new
  modport source (input valid, input arch_dest, output t_new, output t_old);

  // rob side
  modport sink (input valid, input arch_dest, input t_new, input t_old);

endinterface

// File: source/rename_types_pkg.sv
package rename_types_pkg;
  import core_sizes_pkg::*;

  // architectural register index
  typedef logic [arch_width-1:0] arch_reg_t;

  // physical register tag
  typedef logic [tag_width-1:0] phys_tag_t;

  // life of one rob slot
  // free until dispatch, waiting until its tag shows up on the cdb,
  // done until it reaches the head and retires
  typedef enum logic [1:0] {
    entry_free    = 2'd0,
    entry_waiting = 2'd1,
    entry_done    = 2'd2
  } rob_state_t;

  // one rob slot
  // t_old goes back to the free list on retire
  typedef struct packed {
    rob_state_t state;
    arch_reg_t  arch_dest;
    phys_tag_t  t_new;
    phys_tag_t  t_old;
  } rob_entry_t;

endpackage

// File: source/core_sizes_pkg.sv
package core_sizes_pkg;

  // architectural register file seen by software
  localparam int num_arch_regs = 8;

  // physical registers behind the rename map
  localparam int num_phys_regs = 16;

  // in-flight window
  localparam int rob_depth = 6;

  // functional units that report completion on the cdb
  localparam int num_units = 3;

  // derived widths
  localparam int arch_width    = $clog2(num_arch_regs);
  localparam int tag_width     = $clog2(num_phys_regs);
  localparam int rob_ptr_width = $clog2(rob_depth);

endpackage
